/* hdl/mem_ctrl_pkg.sv */
// shared geometry, latency and encoding constants that every block of the memory controller imports
`default_nettype none

package mem_ctrl_pkg;

	// bus widths
	localparam int ADDR_W = 16;     // word address
	localparam int DATA_W = 16;     // one processor word

	// cache geometry
	localparam int WORD_BITS   = 2;                               // offset inside a block
	localparam int BLOCK_WORDS = 2 ** WORD_BITS;                  // four words per block
	localparam int INDEX_BITS  = 3;                               // line select
	localparam int LINES       = 2 ** INDEX_BITS;                 // eight lines per cache
	localparam int TAG_BITS    = ADDR_W - INDEX_BITS - WORD_BITS; // 11 upper bits

	// main memory
	localparam int MEM_WORDS   = 2 ** ADDR_W;          // full 64k word space
	localparam int MEM_LATENCY = 4;                    // en to valid, in cycles
	localparam int LAT_W       = $clog2(MEM_LATENCY);  // holds MEM_LATENCY-1
	localparam logic [DATA_W-1:0] MEM_INIT_KEY = 16'hA5A5; // word a starts as a ^ key

	// fill FSM states
	typedef enum logic [1:0] {
		IDLE   = 2'b00, // waiting for a miss
		FILL_I = 2'b01, // block fill into the instruction cache
		FILL_D = 2'b10, // block fill into the data cache
		STORE  = 2'b11  // write-through of one data word
	} fill_state_t;

	// per-cache operation from the FSM
	typedef enum logic [1:0] {
		READ      = 2'b00, // plain lookup, no write
		DATA_FILL = 2'b01, // write one returned word
		TAG_FILL  = 2'b10, // write tag and set valid
		STORE_UPD = 2'b11  // update a cached word on a store
	} cache_op_t;

endpackage

`default_nettype wire

/* hdl/mem_ctrl_ifs.sv */
// bundles between the fill FSM and the main memory and between the FSM and each cache
`timescale 1ns/1ps
`default_nettype none

// fill FSM to main memory
// en pulses once per access and valid pulses MEM_LATENCY cycles later
interface mem_bus_if import mem_ctrl_pkg::*; ();

	logic [ADDR_W-1:0] addr;  // word address, sampled on en
	logic [DATA_W-1:0] wdata; // store data, sampled on en
	logic [DATA_W-1:0] rdata; // read word, good while valid
	logic              en;    // one cycle start strobe
	logic              wr;    // write when set at en
	logic              valid; // one cycle done strobe

	modport ctrl (
		output addr, wdata, en, wr,
		input  rdata, valid
	);

	modport mem (
		input  addr, wdata, en, wr,
		output rdata, valid
	);

endinterface

// fill FSM to one cache
interface cache_fill_if import mem_ctrl_pkg::*; ();

	cache_op_t         op;       // READ except in a write cycle
	logic [WORD_BITS-1:0] word;  // block word for DATA_FILL
	logic [DATA_W-1:0] wdata;    // word to write
	logic              hit_line; // addressed line valid with matching tag

	modport fsm (
		output op, word, wdata,
		input  hit_line
	);

	modport cache (
		input  op, word, wdata,
		output hit_line
	);

endinterface

`default_nettype wire

/* hdl/direct_cache.sv */
// direct-mapped cache for one processor bus, looked up combinationally and written by the fill FSM
`timescale 1ns/1ps
`default_nettype none

module direct_cache import mem_ctrl_pkg::*; (
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire logic              en,       // low bypasses the cache entirely
	input  wire logic [ADDR_W-1:0] addr,     // held steady while miss is high
	input  wire logic              we,       // store request
	cache_fill_if.cache            fill,     // writes from the fill FSM
	output logic      [DATA_W-1:0] data_out, // zero while missing or disabled
	output logic                   miss      // stall level to the pipeline
);

	// address split
	logic [TAG_BITS-1:0]   tag;
	logic [INDEX_BITS-1:0] index;
	logic [WORD_BITS-1:0]  offs;

	// storage
	logic [DATA_W-1:0]   data_mem [LINES*BLOCK_WORDS]; // words stored line after line
	logic [TAG_BITS-1:0] tag_mem  [LINES];
	logic [LINES-1:0]    valid_q;                      // one bit per line

	logic store_ack; // FSM finishing the write-through this cycle

	assign tag   = addr[ADDR_W-1 -: TAG_BITS];
	assign index = addr[WORD_BITS +: INDEX_BITS];
	assign offs  = addr[WORD_BITS-1:0];

	assign fill.hit_line = valid_q[index] && (tag_mem[index] == tag);

	// a store always misses so the FSM pushes it through to memory
	// the miss is released in the update cycle whether the line is present or not
	assign store_ack = (fill.op == STORE_UPD);
	assign miss      = en && (we ? !store_ack : !fill.hit_line);

	assign data_out = (en && !miss) ? data_mem[{index, offs}] : '0; // combinational hit path

	// valid bits
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= '0; // every line empty after reset
		end else if (fill.op == TAG_FILL) begin
			valid_q[index] <= 1'b1; // tag goes in last so the line opens complete
		end
	end

	// data and tag arrays
	always_ff @(posedge clk) begin
		case (fill.op)
			DATA_FILL: begin
				data_mem[{index, fill.word}] <= fill.wdata; // word from the block fill
			end
			TAG_FILL: begin
				tag_mem[index] <= tag;
			end
			STORE_UPD: begin
				if (fill.hit_line)
					data_mem[{index, offs}] <= fill.wdata; // no allocate on a store miss
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

/* hdl/main_memory.sv */
// word-addressed main memory behind both caches, one access at a time with a fixed latency
`timescale 1ns/1ps
`default_nettype none

module main_memory import mem_ctrl_pkg::*; (
	input  wire logic clk,
	input  wire logic rst_n,
	mem_bus_if.mem    bus    // access port from the fill FSM
);

	logic [DATA_W-1:0] mem_array [MEM_WORDS];

	// access held from en until valid
	logic [ADDR_W-1:0] addr_q;
	logic [DATA_W-1:0] wdata_q;
	logic              wr_q;
	logic [DATA_W-1:0] rdata_q;

	// latency tracking
	logic             busy_q;
	logic [LAT_W-1:0] cnt_q;  // cycles left before the strobe
	logic             fire;   // last cycle before valid
	logic             valid_q;

	// contents follow a fixed rule so any word can be predicted
	initial begin
		for (int a = 0; a < MEM_WORDS; a++)
			mem_array[a] = ADDR_W'(a) ^ MEM_INIT_KEY;
	end

	assign fire = busy_q && (cnt_q == LAT_W'(1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy_q  <= 1'b0;
			cnt_q   <= '0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= fire; // lands exactly MEM_LATENCY cycles after en
			if (bus.en) begin
				busy_q <= 1'b1;
				cnt_q  <= LAT_W'(MEM_LATENCY - 1);
			end else if (busy_q) begin
				cnt_q <= cnt_q - 1'b1;
				if (fire)
					busy_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (bus.en) begin
			addr_q  <= bus.addr;
			wdata_q <= bus.wdata;
			wr_q    <= bus.wr;
		end
		if (fire)
			rdata_q <= mem_array[addr_q]; // ready in the valid cycle
		if (valid_q && wr_q)
			mem_array[addr_q] <= wdata_q; // store commits with its strobe
	end

	assign bus.rdata = rdata_q;
	assign bus.valid = valid_q;

endmodule

`default_nettype wire

/* hdl/fill_counter.sv */
// word index counter that walks the fill FSM through one cache block
`timescale 1ns/1ps
`default_nettype none

module fill_counter import mem_ctrl_pkg::*; (
	input  wire logic                 clk,
	input  wire logic                 rst_n,
	input  wire logic                 start,     // back to word zero
	input  wire logic                 step,      // one word returned by memory
	output logic      [WORD_BITS-1:0] word,      // current word in the block
	output logic                      last_word  // final word of the block
);

	logic [WORD_BITS-1:0] word_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			word_q <= '0;
		end else if (start) begin
			word_q <= '0;
		end else if (step) begin
			word_q <= word_q + 1'b1; // wraps to zero after the last word
		end
	end

	assign word = word_q;

	// the FSM moves to the tag write once this word comes back
	assign last_word = (word_q == WORD_BITS'(BLOCK_WORDS - 1));

endmodule

`default_nettype wire

/* hdl/fill_fsm.sv */
// fill FSM that arbitrates the two cache misses and runs block fills and write-through stores
`timescale 1ns/1ps
`default_nettype none

module fill_fsm import mem_ctrl_pkg::*; (
	input  wire logic                 clk,
	input  wire logic                 rst_n,
	input  wire logic                 if_miss,    // fetch cache miss level
	input  wire logic                 dm_miss,    // data cache miss level
	input  wire logic                 dm_we,      // data bus store
	input  wire logic [ADDR_W-1:0]    if_addr,
	input  wire logic [ADDR_W-1:0]    dm_addr,
	input  wire logic [DATA_W-1:0]    dm_data_in, // store data
	mem_bus_if.ctrl                   mem,        // main memory port
	cache_fill_if.fsm                 i_fill,     // fetch cache writes
	cache_fill_if.fsm                 d_fill,     // data cache writes
	output logic                      cnt_start,
	output logic                      cnt_step,
	input  wire logic [WORD_BITS-1:0] word,       // from fill_counter
	input  wire logic                 last_word
);

	fill_state_t state, next_state;

	logic req_q;   // issue the next word read this cycle
	logic fin_q;   // tag write or store update this cycle
	logic req_i, req_fill_d, req_store;
	logic sel_i;   // fetch side owns the memory
	logic do_store;
	logic filling;
	logic [ADDR_W-1:0] src_addr;
	cache_op_t fill_op;

	// requests seen in IDLE with the fetch side first
	assign req_i      = if_miss && !i_fill.hit_line;
	assign req_store  = !req_i && dm_miss && dm_we;             // write-through, hit or not
	assign req_fill_d = !req_i && dm_miss && !dm_we && !d_fill.hit_line;

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (req_i)
					next_state = FILL_I;
				else if (req_store)
					next_state = STORE;
				else if (req_fill_d)
					next_state = FILL_D;
			end
			default: begin
				if (fin_q)
					next_state = IDLE; // miss drops once the cache is written
			end
		endcase
	end

	// the first access leaves in the same cycle the miss is seen
	assign sel_i    = (state == IDLE) ? req_i : (state == FILL_I);
	assign do_store = (state == IDLE) ? req_store : (state == STORE);
	assign filling  = (state == FILL_I) || (state == FILL_D);
	assign src_addr = sel_i ? if_addr : dm_addr;

	assign mem.en    = ((state == IDLE) && (next_state != IDLE)) || req_q;
	assign mem.wr    = do_store;
	assign mem.addr  = do_store ? dm_addr : {src_addr[ADDR_W-1:WORD_BITS], word}; // block base plus word
	assign mem.wdata = dm_data_in;

	assign cnt_start = (state == IDLE);
	assign cnt_step  = filling && mem.valid;

	// returned words go straight into the cache and the tag one cycle after the last
	assign fill_op = fin_q ? TAG_FILL : (mem.valid ? DATA_FILL : READ);

	assign i_fill.op    = (state == FILL_I) ? fill_op : READ;
	assign i_fill.word  = word;
	assign i_fill.wdata = mem.rdata;

	assign d_fill.op    = (state == FILL_D) ? fill_op :
			((state == STORE) && fin_q) ? STORE_UPD : READ;
	assign d_fill.word  = word;
	assign d_fill.wdata = (state == STORE) ? dm_data_in : mem.rdata;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
			req_q <= 1'b0;
			fin_q <= 1'b0;
		end else begin
			state <= next_state;
			req_q <= cnt_step && !last_word;                          // next word after valid
			fin_q <= mem.valid && ((state == STORE) || last_word);    // closing cycle
		end
	end

endmodule

`default_nettype wire

/* hdl/mem_ctrl_top.sv */
// memory controller top serving the fetch and data buses from two caches over one main memory
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl_top import mem_ctrl_pkg::*; (
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire logic              d_enable,    // low bypasses the data cache
	// fetch bus
	input  wire logic [ADDR_W-1:0] if_addr,
	output logic      [DATA_W-1:0] if_data_out,
	output logic                   if_miss,     // pipeline stall for fetch
	// data bus
	input  wire logic [ADDR_W-1:0] dm_addr,
	input  wire logic              dm_we,       // store
	input  wire logic [DATA_W-1:0] dm_data_in,
	output logic      [DATA_W-1:0] dm_data_out,
	output logic                   dm_miss      // pipeline stall for data
);

	// counter to FSM
	logic [WORD_BITS-1:0] word;
	logic                 last_word;
	logic                 cnt_start;
	logic                 cnt_step;

	mem_bus_if    mem_bus ();   // FSM to main memory
	cache_fill_if i_fill_bus (); // FSM to fetch cache
	cache_fill_if d_fill_bus (); // FSM to data cache

	// fetch cache never stores and is always on
	direct_cache i_cache (
		.clk      (clk),
		.rst_n    (rst_n),
		.en       (1'b1),
		.addr     (if_addr),
		.we       (1'b0),
		.fill     (i_fill_bus.cache),
		.data_out (if_data_out),
		.miss     (if_miss)
	);

	// data cache, silent when d_enable is low
	direct_cache d_cache (
		.clk      (clk),
		.rst_n    (rst_n),
		.en       (d_enable),
		.addr     (dm_addr),
		.we       (dm_we),
		.fill     (d_fill_bus.cache),
		.data_out (dm_data_out),
		.miss     (dm_miss)
	);

	main_memory u_mem (
		.clk   (clk),
		.rst_n (rst_n),
		.bus   (mem_bus.mem)
	);

	fill_counter u_cnt (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (cnt_start),
		.step      (cnt_step),
		.word      (word),
		.last_word (last_word)
	);

	// for debug watch u_fsm.state of type fill_state_t
	// IDLE until a miss, then FILL_I or FILL_D for 21 cycles or STORE for 6
	fill_fsm u_fsm (
		.clk        (clk),
		.rst_n      (rst_n),
		.if_miss    (if_miss),
		.dm_miss    (dm_miss),
		.dm_we      (dm_we),
		.if_addr    (if_addr),
		.dm_addr    (dm_addr),
		.dm_data_in (dm_data_in),
		.mem        (mem_bus.ctrl),
		.i_fill     (i_fill_bus.fsm),
		.d_fill     (d_fill_bus.fsm),
		.cnt_start  (cnt_start),
		.cnt_step   (cnt_step),
		.word       (word),
		.last_word  (last_word)
	);

endmodule

`default_nettype wire

/* testbench/tb_mem_ctrl.sv */
// self-checking testbench for mem_ctrl_top that replays the golden vectors on the fetch and data buses
`timescale 1ns/1ps
`default_nettype none

module tb_mem_ctrl import mem_ctrl_pkg::*; ();

	logic              clk;
	logic              rst_n;
	logic              d_enable;
	logic [ADDR_W-1:0] if_addr;
	logic [DATA_W-1:0] if_data_out;
	logic              if_miss;
	logic [ADDR_W-1:0] dm_addr;
	logic              dm_we;
	logic [DATA_W-1:0] dm_data_in;
	logic [DATA_W-1:0] dm_data_out;
	logic              dm_miss;

	// golden vectors with one entry per line of the file
	logic [31:0]       t_op [$];   // up to four ascii chars
	logic [ADDR_W-1:0] t_ia [$];
	logic [ADDR_W-1:0] t_da [$];
	logic [DATA_W-1:0] t_wd [$];
	logic [DATA_W-1:0] t_ie [$];   // expected fetch word
	logic [DATA_W-1:0] t_de [$];   // expected data word
	logic              t_m  [$];   // expected miss in the first cycle

	int     cycles = 0;
	int     limit = 0;      // zero until the vectors are loaded
	int     passes = 0;
	int     fails = 0;
	int     errors = 0;
	int     test_errs = 0;
	int     tnum = 0;
	integer seed = 33;

	mem_ctrl_top DUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.d_enable    (d_enable),
		.if_addr     (if_addr),
		.if_data_out (if_data_out),
		.if_miss     (if_miss),
		.dm_addr     (dm_addr),
		.dm_we       (dm_we),
		.dm_data_in  (dm_data_in),
		.dm_data_out (dm_data_out),
		.dm_miss     (dm_miss)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// watchdog
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("run timed out after %0d cycles, a miss never fell", cycles);
			$display("Done: errors found");
			$finish;
		end
	end

	task automatic compare(input string name, input logic [DATA_W-1:0] got, exp);
		if (got !== exp) begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			test_errs++;
		end
	endtask

	task automatic log_result(input logic [31:0] op);
		tnum++;
		if (test_errs == 0) begin
			passes++;
			$display("PASS test %0d %s", tnum, op);
		end else begin
			fails++;
			errors += test_errs;
			$display("FAIL test %0d %s", tnum, op);
		end
		test_errs = 0;
	endtask

	// drive a fetch, check the first-cycle miss, then the word once the miss drops
	task automatic fetch_check(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] exp,
			input logic m);
		@(posedge clk);
		if_addr <= a;
		@(negedge clk);
		compare("if_miss", DATA_W'(if_miss), DATA_W'(m));
		while (if_miss) @(negedge clk);
		compare("if_data_out", if_data_out, exp);
	endtask

	// load or store on the data bus with the cache enabled
	task automatic data_access(input logic [ADDR_W-1:0] a, input logic we,
			input logic [DATA_W-1:0] wd, exp, input logic m);
		@(posedge clk);
		dm_addr    <= a;
		dm_we      <= we;
		dm_data_in <= wd;
		d_enable   <= 1'b1;
		@(negedge clk);
		compare("dm_miss", DATA_W'(dm_miss), DATA_W'(m));
		while (dm_miss) @(negedge clk);
		if (we) begin
			@(posedge clk);
			dm_we <= 1'b0; // release before the FSM sees the finished store again
		end else begin
			compare("dm_data_out", dm_data_out, exp);
		end
	endtask

	// both buses miss together and the fetch side has to finish first
	task automatic dual_miss(input int i);
		int t;
		int t_if;
		int t_dm;
		t_if = -1;
		t_dm = -1;
		@(posedge clk);
		if_addr  <= t_ia[i];
		dm_addr  <= t_da[i];
		dm_we    <= 1'b0;
		d_enable <= 1'b1;
		@(negedge clk);
		compare("if_miss", DATA_W'(if_miss), DATA_W'(t_m[i]));
		compare("dm_miss", DATA_W'(dm_miss), DATA_W'(t_m[i]));
		for (t = 0; t_if < 0 || t_dm < 0; t++) begin
			if (t > 0)
				@(negedge clk);
			if (t_if < 0 && !if_miss)
				t_if = t; // first cycle with the fetch stall gone
			if (t_dm < 0 && !dm_miss)
				t_dm = t;
		end
		if (!(t_if < t_dm)) begin
			$display("fetch miss fell at cycle %0d, not before data miss at %0d", t_if, t_dm);
			test_errs++;
		end
		compare("if_data_out", if_data_out, t_ie[i]);
		compare("dm_data_out", dm_data_out, t_de[i]);
	endtask

	// fetch while the data cache is off and a store is offered to it
	task automatic disabled_fetch(input int i);
		logic stray_miss;
		@(posedge clk);
		if_addr    <= t_ia[i];
		dm_addr    <= t_da[i];
		dm_we      <= 1'b1;
		dm_data_in <= t_wd[i];
		d_enable   <= 1'b0;
		@(negedge clk);
		compare("if_miss", DATA_W'(if_miss), DATA_W'(t_m[i]));
		stray_miss = dm_miss;
		while (if_miss) begin
			@(negedge clk);
			stray_miss |= dm_miss; // must stay low through the whole fetch fill
		end
		if (stray_miss) begin
			$display("dm_miss went high while the data cache was disabled");
			test_errs++;
		end
		compare("if_data_out", if_data_out, t_ie[i]);
		compare("dm_data_out", dm_data_out, t_de[i]);
		@(posedge clk);
		dm_we    <= 1'b0; // both change together so no store slips through
		d_enable <= 1'b1;
	endtask

	// extra read at a random word of the block just fetched
	task automatic filler_read(input logic [ADDR_W-1:0] base);
		int r;
		logic [ADDR_W-1:0] a;
		r = $random(seed);
		a = {base[ADDR_W-1:WORD_BITS], r[WORD_BITS-1:0]};
		fetch_check(a, a ^ 16'hA5A5, 1'b0);
	endtask

	initial begin
		int fd;
		int code;
		logic [31:0] op;
		logic [8*96-1:0] line;
		logic [15:0] ia, da, wd, ie, de, m;
		rst_n      = 1'b0;
		d_enable   = 1'b1;
		if_addr    = '0;
		dm_addr    = '0;
		dm_we      = 1'b0;
		dm_data_in = '0;
		fd = $fopen("testbench/mem_ctrl_golden.txt", "r");
		if (fd == 0) begin
			$display("could not open testbench/mem_ctrl_golden.txt");
			$display("Done: errors found");
			$finish;
		end else begin
			while (!$feof(fd)) begin
				code = $fscanf(fd, "%s", op);
				if (code == 1 && op == "#") begin
					code = $fgets(line, fd); // comment line
				end else if (code == 1) begin
					code = $fscanf(fd, "%h %h %h %h %h %h", ia, da, wd, ie, de, m);
					t_op.push_back(op);
					t_ia.push_back(ia);
					t_da.push_back(da);
					t_wd.push_back(wd);
					t_ie.push_back(ie);
					t_de.push_back(de);
					t_m.push_back(m[0]);
				end
			end
			$fclose(fd);
			limit = t_op.size() * 2 * (BLOCK_WORDS * (MEM_LATENCY + 1) + 1) + 200;
			repeat (10) @(posedge clk);
			rst_n <= 1'b1;
			@(negedge clk);
			while (if_miss || dm_miss) @(negedge clk); // block zero fills on both sides
			foreach (t_op[i]) begin
				case (t_op[i])
					"IF":   fetch_check(t_ia[i], t_ie[i], t_m[i]);
					"LD":   data_access(t_da[i], 1'b0, t_wd[i], t_de[i], t_m[i]);
					"ST":   data_access(t_da[i], 1'b1, t_wd[i], t_de[i], t_m[i]);
					"BOTH": dual_miss(i);
					"DIS":  disabled_fetch(i);
					default: begin
						$display("golden line %0d has an unknown operation", i);
						test_errs++;
					end
				endcase
				log_result(t_op[i]);
				if (t_op[i] == "IF") begin
					filler_read(t_ia[i]);
					log_result("FILL");
				end
			end
			$display("tests %0d passed, %0d failed, %0d bad checks", passes, fails, errors);
			if (fails == 0 && passes > 0)
				$display("Done: no errors");
			else
				$display("Done: errors found");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* testbench/mem_ctrl_golden.txt */
# op if_addr dm_addr wdata if_exp dm_exp miss, all values hex
# miss is the expected miss level of the addressed bus in the first cycle
IF   0124 0000 0000 A481 0000 1
IF   0126 0000 0000 A483 0000 0
LD   0000 0248 0000 0000 A7ED 1
LD   0000 0249 0000 0000 A7EC 0
LD   0000 024A 0000 0000 A7EF 0
LD   0000 024B 0000 0000 A7EE 0
ST   0000 0249 1234 0000 0000 1
LD   0000 0249 0000 0000 1234 0
LD   0000 0248 0000 0000 A7ED 0
ST   0000 0330 BEEF 0000 0000 1
LD   0000 0330 0000 0000 BEEF 1
BOTH 0410 0514 0000 A1B5 A0B1 1
DIS  0600 0700 DEAD A3A5 0000 1
LD   0000 0700 0000 0000 A2A5 1
IF   0128 0000 0000 A48D 0000 1
IF   0928 0000 0000 AC8D 0000 1
IF   0129 0000 0000 A48C 0000 1
IF   092A 0000 0000 AC8F 0000 1

/* files.f */
hdl/mem_ctrl_pkg.sv
hdl/mem_ctrl_ifs.sv
hdl/direct_cache.sv
hdl/main_memory.sv
hdl/fill_counter.sv
hdl/fill_fsm.sv
hdl/mem_ctrl_top.sv
testbench/tb_mem_ctrl.sv

/* Bender.yml */
package:
  name: mem_ctrl

sources:
  - hdl/mem_ctrl_pkg.sv
  - hdl/mem_ctrl_ifs.sv
  - hdl/direct_cache.sv
  - hdl/main_memory.sv
  - hdl/fill_counter.sv
  - hdl/fill_fsm.sv
  - hdl/mem_ctrl_top.sv
  - target: test
    files:
      - testbench/tb_mem_ctrl.sv
